//--- common/cacheGeomPkg.sv
package cacheGeomPkg;

	// ------------------------------------------------------------
	// cache geometry
	// ------------------------------------------------------------
	localparam int addrWidth = 32;
	localparam int wordWidth = 32;
	localparam int wordsPerLine = 4;
	localparam int numSets = 16;
	localparam int numWays = 2;

	// tag | index | word | byte from the top
	localparam int offsetBits = 4; // byte offset within a line
	localparam int indexBits = 4;
	localparam int tagBits = addrWidth - indexBits - offsetBits;

	// ------------------------------------------------------------
	// types
	// ------------------------------------------------------------
	typedef logic [addrWidth-1:0] addrT;
	typedef logic [wordWidth-1:0] wordT;
	typedef logic [wordsPerLine*wordWidth-1:0] lineT; // word 0 in low bits
	typedef logic [tagBits-1:0] tagT;
	typedef logic [indexBits-1:0] indexT;
	typedef logic [$clog2(wordsPerLine)-1:0] wordSelT;
	typedef logic [$clog2(numWays)-1:0] wayT;

endpackage

//--- common/cacheCtrlPkg.sv
package cacheCtrlPkg;

	// command encoding
	typedef enum logic [1:0] {
		cmdNone = 2'd0,
		cmdRead = 2'd1,
		cmdWrite = 2'd2,
		cmdInvalidate = 2'd3
	} cmdT;

	// controller FSM
	typedef enum logic [2:0] {
		sIdle,
		sLookup,
		sWriteBack,
		sFill,
		sRespond
	} ctrlStateT;

endpackage

//--- common/lineAccessIf.sv
`timescale 1ns/100ps

interface lineAccessIf;
	// addressing from the controller
	cacheGeomPkg::indexT index;
	cacheGeomPkg::tagT tag;
	cacheGeomPkg::wordSelT wordSel;
	cacheGeomPkg::wayT accessWay;

	// update strobes
	logic touch;
	logic wordWrite;
	cacheGeomPkg::wordT wordData;
	logic fill;
	cacheGeomPkg::lineT fillLine;
	logic dropLine;

	// combinational lookup results
	logic hit;
	cacheGeomPkg::wayT hitWay;
	cacheGeomPkg::wayT victimWay;
	logic wayDirty;
	cacheGeomPkg::tagT wayTag;
	cacheGeomPkg::lineT wayLine;
	cacheGeomPkg::wordT wayWord;

	modport ctrl (
		output index, tag, wordSel, accessWay, touch, wordWrite, wordData,
		output fill, fillLine, dropLine,
		input hit, hitWay, victimWay, wayDirty, wayTag, wayLine, wayWord
	);

	modport arrays (
		input index, tag, wordSel, accessWay, touch, wordWrite, wordData,
		input fill, fillLine, dropLine,
		output hit, hitWay, victimWay, wayDirty, wayTag, wayLine, wayWord
	);
endinterface

//--- common/memReqIf.sv
`timescale 1ns/100ps

interface memReqIf;
	logic startFill;
	cacheGeomPkg::addrT fillAddr;
	logic startWriteBack;
	cacheGeomPkg::addrT wbAddr;
	cacheGeomPkg::lineT wbLine;

	logic fillDone;
	cacheGeomPkg::lineT filledLine;
	logic wbDone;

	modport ctrl (
		output startFill, fillAddr, startWriteBack, wbAddr, wbLine,
		input fillDone, filledLine, wbDone
	);

	modport mem (
		input startFill, fillAddr, startWriteBack, wbAddr, wbLine,
		output fillDone, filledLine, wbDone
	);
endinterface

//--- cache/cacheArrays.sv
`timescale 1ns/100ps

module cacheArrays (
	input logic clk,
	input logic reset,
	lineAccessIf.arrays lines
);

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------
	cacheGeomPkg::tagT tagMem [cacheGeomPkg::numWays][cacheGeomPkg::numSets];
	cacheGeomPkg::lineT dataMem [cacheGeomPkg::numWays][cacheGeomPkg::numSets];
	logic [cacheGeomPkg::numWays-1:0] validBits [cacheGeomPkg::numSets];
	logic [cacheGeomPkg::numWays-1:0] dirtyBits [cacheGeomPkg::numSets];
	cacheGeomPkg::wayT lruWay [cacheGeomPkg::numSets]; // way to evict next

	logic [cacheGeomPkg::numWays-1:0] hitVec;
	cacheGeomPkg::lineT selLine;

	// ------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < cacheGeomPkg::numWays; w++) begin
			hitVec[w] = validBits[lines.index][w] &&
				(tagMem[w][lines.index] == lines.tag);
		end
	end

	assign lines.hit = |hitVec;
	assign lines.hitWay = hitVec[1] ? 1'b1 : 1'b0;

	// empty way first, way 0 before way 1
	always_comb begin
		if (!validBits[lines.index][0])
			lines.victimWay = 1'b0;
		else if (!validBits[lines.index][1])
			lines.victimWay = 1'b1;
		else
			lines.victimWay = lruWay[lines.index];
	end

	assign selLine = dataMem[lines.accessWay][lines.index];
	assign lines.wayLine = selLine;
	assign lines.wayTag = tagMem[lines.accessWay][lines.index];
	assign lines.wayDirty = validBits[lines.index][lines.accessWay] &&
		dirtyBits[lines.index][lines.accessWay]; // invalid lines never count as dirty
	assign lines.wayWord =
		selLine[lines.wordSel*cacheGeomPkg::wordWidth +: cacheGeomPkg::wordWidth];

	// ------------------------------------------------------------
	// updates
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (lines.fill) begin
			dataMem[lines.accessWay][lines.index] <= lines.fillLine;
			tagMem[lines.accessWay][lines.index] <= lines.tag;
			dirtyBits[lines.index][lines.accessWay] <= 1'b0;
		end else if (lines.wordWrite) begin
			dataMem[lines.accessWay][lines.index]
				[lines.wordSel*cacheGeomPkg::wordWidth +: cacheGeomPkg::wordWidth] <=
				lines.wordData;
			dirtyBits[lines.index][lines.accessWay] <= 1'b1;
		end
		if (lines.dropLine)
			dirtyBits[lines.index][lines.accessWay] <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < cacheGeomPkg::numSets; s++) begin
				validBits[s] <= '0;
				lruWay[s] <= '0;
			end
		end else begin
			if (lines.fill)
				validBits[lines.index][lines.accessWay] <= 1'b1;
			if (lines.dropLine)
				validBits[lines.index][lines.accessWay] <= 1'b0;
			if (lines.fill || lines.wordWrite || lines.touch)
				lruWay[lines.index] <= ~lines.accessWay; // other way becomes LRU
		end
	end

	// controller must never allocate a line that is already resident
	assert property (@(posedge clk) disable iff (reset) !(&hitVec))
		else $error("tag valid in both ways of set %0d", lines.index);

endmodule

//--- cache/cacheController.sv
`timescale 1ns/100ps

module cacheController (
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input cacheCtrlPkg::cmdT cmd,
	input cacheGeomPkg::addrT addr,
	input cacheGeomPkg::wordT wdata,
	output logic busy,
	output logic respValid,
	output cacheGeomPkg::wordT rdata,
	lineAccessIf.ctrl lines,
	memReqIf.ctrl mem
);

	cacheCtrlPkg::ctrlStateT state, nextState;

	// captured request
	cacheCtrlPkg::cmdT reqCmd;
	cacheGeomPkg::tagT reqTag;
	cacheGeomPkg::indexT reqIndex;
	cacheGeomPkg::wordSelT reqWord;
	cacheGeomPkg::wordT reqData;
	cacheGeomPkg::wayT workWay; // way chosen in lookup
	logic captureWord;

	assign busy = (state != cacheCtrlPkg::sIdle);
	assign respValid = (state == cacheCtrlPkg::sRespond);

	assign lines.index = reqIndex;
	assign lines.tag = reqTag;
	assign lines.wordSel = reqWord;
	assign lines.wordData = reqData;
	assign lines.fillLine = mem.filledLine;

	assign mem.fillAddr = {reqTag, reqIndex, {cacheGeomPkg::offsetBits{1'b0}}};
	assign mem.wbAddr = {lines.wayTag, reqIndex, {cacheGeomPkg::offsetBits{1'b0}}};
	assign mem.wbLine = lines.wayLine;

	// ------------------------------------------------------------
	// next state and strobes
	// ------------------------------------------------------------
	always_comb begin
		nextState = state;
		lines.touch = 1'b0;
		lines.wordWrite = 1'b0;
		lines.fill = 1'b0;
		lines.dropLine = 1'b0;
		mem.startFill = 1'b0;
		mem.startWriteBack = 1'b0;
		captureWord = 1'b0;
		if (state == cacheCtrlPkg::sLookup)
			lines.accessWay = lines.hit ? lines.hitWay : lines.victimWay;
		else
			lines.accessWay = workWay;

		case (state)
			cacheCtrlPkg::sIdle:
				if (cmdValid) nextState = cacheCtrlPkg::sLookup;
			cacheCtrlPkg::sLookup: begin
				if (reqCmd == cacheCtrlPkg::cmdNone) begin
					nextState = cacheCtrlPkg::sRespond;
				end else if (reqCmd == cacheCtrlPkg::cmdInvalidate) begin
					if (lines.hit && lines.wayDirty) begin
						mem.startWriteBack = 1'b1;
						nextState = cacheCtrlPkg::sWriteBack;
					end else begin
						lines.dropLine = lines.hit;
						nextState = cacheCtrlPkg::sRespond;
					end
				end else if (lines.hit) begin
					if (reqCmd == cacheCtrlPkg::cmdWrite) begin
						lines.wordWrite = 1'b1;
					end else begin
						lines.touch = 1'b1;
						captureWord = 1'b1;
					end
					nextState = cacheCtrlPkg::sRespond;
				end else if (lines.wayDirty) begin
					mem.startWriteBack = 1'b1; // victim out first
					nextState = cacheCtrlPkg::sWriteBack;
				end else begin
					mem.startFill = 1'b1;
					nextState = cacheCtrlPkg::sFill;
				end
			end
			cacheCtrlPkg::sWriteBack:
				if (mem.wbDone) begin
					if (reqCmd == cacheCtrlPkg::cmdInvalidate) begin
						lines.dropLine = 1'b1;
						nextState = cacheCtrlPkg::sRespond;
					end else begin
						mem.startFill = 1'b1;
						nextState = cacheCtrlPkg::sFill;
					end
				end
			cacheCtrlPkg::sFill:
				if (mem.fillDone) begin
					lines.fill = 1'b1;
					nextState = cacheCtrlPkg::sLookup; // replay as a hit
				end
			cacheCtrlPkg::sRespond:
				nextState = cacheCtrlPkg::sIdle;
			default:
				nextState = cacheCtrlPkg::sIdle;
		endcase
	end

	// ------------------------------------------------------------
	// registers
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			state <= cacheCtrlPkg::sIdle;
		else
			state <= nextState;
	end

	always_ff @(posedge clk) begin
		if (state == cacheCtrlPkg::sIdle && cmdValid) begin
			reqCmd <= cmd;
			reqTag <= addr[cacheGeomPkg::addrWidth-1 -: cacheGeomPkg::tagBits];
			reqIndex <= addr[cacheGeomPkg::offsetBits +: cacheGeomPkg::indexBits];
			reqWord <= addr[cacheGeomPkg::offsetBits-1 -: $bits(cacheGeomPkg::wordSelT)];
			reqData <= wdata;
			rdata <= '0;
		end
		if (state == cacheCtrlPkg::sLookup)
			workWay <= lines.accessWay;
		if (captureWord)
			rdata <= lines.wayWord;
	end

	assert property (@(posedge clk) disable iff (reset) !(lines.fill && lines.wordWrite))
		else $error("fill and word write in the same cycle");

	assert property (@(posedge clk) disable iff (reset)
		(mem.startFill || mem.startWriteBack) |->
			state inside {cacheCtrlPkg::sLookup, cacheCtrlPkg::sWriteBack,
				cacheCtrlPkg::sFill})
		else $error("memory start outside lookup or miss handling");

endmodule

//--- logic/memRequester.sv
`timescale 1ns/100ps

module memRequester (
	input logic clk,
	input logic reset,
	memReqIf.mem req,
	output logic memRdReq,
	output cacheGeomPkg::addrT memRdAddr,
	input logic memRdValid,
	input cacheGeomPkg::lineT memRdData,
	output logic memWrReq,
	output cacheGeomPkg::addrT memWrAddr,
	output cacheGeomPkg::lineT memWrData,
	input logic memWrDone
);

	logic pending;
	logic pendingWb; // kind of the request in flight

	// ------------------------------------------------------------
	// strobes and pending tracking
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
			pendingWb <= 1'b0;
			memRdReq <= 1'b0;
			memWrReq <= 1'b0;
			req.fillDone <= 1'b0;
			req.wbDone <= 1'b0;
		end else begin
			memRdReq <= req.startFill;
			memWrReq <= req.startWriteBack;
			req.fillDone <= memRdValid;
			req.wbDone <= memWrDone;
			if (req.startFill || req.startWriteBack) begin
				pending <= 1'b1;
				pendingWb <= req.startWriteBack;
			end else if (memRdValid || memWrDone) begin
				pending <= 1'b0;
			end
		end
	end

	// line and addresses in flight
	always_ff @(posedge clk) begin
		if (req.startFill)
			memRdAddr <= req.fillAddr;
		if (req.startWriteBack) begin
			memWrAddr <= req.wbAddr;
			memWrData <= req.wbLine;
		end
		if (memRdValid)
			req.filledLine <= memRdData;
	end

	assert property (@(posedge clk) disable iff (reset)
		(req.startFill || req.startWriteBack) |-> !pending)
		else $error("memory start while a request is pending");

	assert property (@(posedge clk) disable iff (reset)
		memRdValid |-> (pending && !pendingWb))
		else $error("memRdValid without a pending fill");

	assert property (@(posedge clk) disable iff (reset)
		memWrDone |-> (pending && pendingWb))
		else $error("memWrDone without a pending write-back");

endmodule

//--- cache/setAssocCache.sv
`timescale 1ns/100ps

module setAssocCache (
	input logic clk,
	input logic reset,
	input logic cmdValid,
	input cacheCtrlPkg::cmdT cmd,
	input cacheGeomPkg::addrT addr,
	input cacheGeomPkg::wordT wdata,
	output logic busy,
	output logic respValid,
	output cacheGeomPkg::wordT rdata,
	output logic memRdReq,
	output cacheGeomPkg::addrT memRdAddr,
	input logic memRdValid,
	input cacheGeomPkg::lineT memRdData,
	output logic memWrReq,
	output cacheGeomPkg::addrT memWrAddr,
	output cacheGeomPkg::lineT memWrData,
	input logic memWrDone
);

	lineAccessIf lineBus ();
	memReqIf memBus ();

	cacheController i_cacheController (
		.clk(clk),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.addr(addr),
		.wdata(wdata),
		.busy(busy),
		.respValid(respValid),
		.rdata(rdata),
		.lines(lineBus.ctrl),
		.mem(memBus.ctrl)
	);

	cacheArrays i_cacheArrays (
		.clk(clk),
		.reset(reset),
		.lines(lineBus.arrays)
	);

	memRequester i_memRequester (
		.clk(clk),
		.reset(reset),
		.req(memBus.mem),
		.memRdReq(memRdReq),
		.memRdAddr(memRdAddr),
		.memRdValid(memRdValid),
		.memRdData(memRdData),
		.memWrReq(memWrReq),
		.memWrAddr(memWrAddr),
		.memWrData(memWrData),
		.memWrDone(memWrDone)
	);

endmodule

//--- test/memModel.sv
`timescale 1ns/100ps

module memModel (
	input logic clk,
	input logic memRdReq,
	input cacheGeomPkg::addrT memRdAddr,
	output logic memRdValid,
	output cacheGeomPkg::lineT memRdData,
	input logic memWrReq,
	input cacheGeomPkg::addrT memWrAddr,
	input cacheGeomPkg::lineT memWrData,
	output logic memWrDone
);

	cacheGeomPkg::wordT store [cacheGeomPkg::addrT]; // keyed by word address
	integer seed = 24;
	int delay;
	cacheGeomPkg::addrT base;

	function automatic cacheGeomPkg::wordT readWord(input cacheGeomPkg::addrT wordAddr);
		if (store.exists(wordAddr))
			return store[wordAddr];
		return wordAddr ^ 32'hA5A5_0000; // never-written pattern
	endfunction

	// one request at a time, sampled on the falling edge
	initial begin
		memRdValid = 1'b0;
		memRdData = '0;
		memWrDone = 1'b0;
		forever begin
			@(negedge clk);
			if (memRdReq || memWrReq) begin
				delay = 1 + ($unsigned($random(seed)) % 8);
				if (memRdReq) begin
					base = memRdAddr >> 2;
					repeat (delay) @(negedge clk);
					for (int w = 0; w < cacheGeomPkg::wordsPerLine; w++)
						memRdData[w*cacheGeomPkg::wordWidth +: cacheGeomPkg::wordWidth] =
							readWord(base + w);
					memRdValid = 1'b1;
					@(negedge clk);
					memRdValid = 1'b0;
				end else begin
					base = memWrAddr >> 2;
					for (int w = 0; w < cacheGeomPkg::wordsPerLine; w++)
						store[base + w] =
							memWrData[w*cacheGeomPkg::wordWidth +: cacheGeomPkg::wordWidth];
					repeat (delay) @(negedge clk);
					memWrDone = 1'b1;
					@(negedge clk);
					memWrDone = 1'b0;
				end
			end
		end
	end

endmodule

//--- test/cacheTb.sv
`timescale 1ns/100ps

module cacheTb;

	localparam int hitLatency = 2; // lookup cycle plus respond cycle
	// about 270 commands, each at most a write-back and a fill of ~20 cycles, plus margin
	localparam int timeoutCycles = 20000;
	localparam int randomCommands = 250;

	typedef struct {
		cacheCtrlPkg::cmdT cmd;
		cacheGeomPkg::addrT addr;
		cacheGeomPkg::wordT data;
		string name;
	} pendingT;

	logic clk;
	logic reset;
	logic cmdValid;
	cacheCtrlPkg::cmdT cmd;
	cacheGeomPkg::addrT addr;
	cacheGeomPkg::wordT wdata;
	logic busy;
	logic respValid;
	cacheGeomPkg::wordT rdata;
	logic memRdReq;
	cacheGeomPkg::addrT memRdAddr;
	logic memRdValid;
	cacheGeomPkg::lineT memRdData;
	logic memWrReq;
	cacheGeomPkg::addrT memWrAddr;
	cacheGeomPkg::lineT memWrData;
	logic memWrDone;

	pendingT reqQ [$];
	pendingT done;
	cacheGeomPkg::wordT shadow [cacheGeomPkg::addrT]; // words written through the cache
	cacheGeomPkg::wordT expWord;
	cacheGeomPkg::wordT wbExpected;
	cacheGeomPkg::addrT lastRdAddr;
	cacheGeomPkg::addrT lastWrAddr;
	cacheGeomPkg::lineT lastWrData;
	cacheGeomPkg::addrT rndAddr;
	cacheGeomPkg::wordT rndData;
	int cycleCount = 0;
	int failCount = 0;
	int rdReqCount = 0;
	int wrReqCount = 0;
	int memEvents = 0;
	int rdEventNo = 0;
	int wrEventNo = 0;
	int rdBefore;
	int wrBefore;
	int lastLatency;
	int pick;
	integer seed = 24;
	string testName;

	setAssocCache i_setAssocCache (
		.clk(clk),
		.reset(reset),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.addr(addr),
		.wdata(wdata),
		.busy(busy),
		.respValid(respValid),
		.rdata(rdata),
		.memRdReq(memRdReq),
		.memRdAddr(memRdAddr),
		.memRdValid(memRdValid),
		.memRdData(memRdData),
		.memWrReq(memWrReq),
		.memWrAddr(memWrAddr),
		.memWrData(memWrData),
		.memWrDone(memWrDone)
	);

	memModel i_memModel (
		.clk(clk),
		.memRdReq(memRdReq),
		.memRdAddr(memRdAddr),
		.memRdValid(memRdValid),
		.memRdData(memRdData),
		.memWrReq(memWrReq),
		.memWrAddr(memWrAddr),
		.memWrData(memWrData),
		.memWrDone(memWrDone)
	);

	always #50 clk = ~clk;

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		failCount++;
		$display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic reportFailure(input string what);
		failCount++;
		$display("ERROR: %s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	function automatic cacheGeomPkg::addrT wordAddress(input int tagNo, input int setNo,
		input int wordNo);
		return (tagNo << (cacheGeomPkg::indexBits + cacheGeomPkg::offsetBits)) |
			(setNo << cacheGeomPkg::offsetBits) | (wordNo << 2);
	endfunction

	// shadow value, else the memory fill pattern
	function automatic cacheGeomPkg::wordT expectedWord(input cacheGeomPkg::addrT byteAddr);
		cacheGeomPkg::addrT wordAddr;
		wordAddr = byteAddr >> 2;
		if (shadow.exists(wordAddr))
			return shadow[wordAddr];
		return wordAddr ^ 32'hA5A5_0000;
	endfunction

	task automatic runCommand(input cacheCtrlPkg::cmdT c, input cacheGeomPkg::addrT a,
		input cacheGeomPkg::wordT d);
		pendingT item;
		int acceptEdge;
		while (busy)
			@(negedge clk);
		item.cmd = c;
		item.addr = a;
		item.data = d;
		item.name = testName;
		reqQ.push_back(item);
		cmdValid = 1'b1;
		cmd = c;
		addr = a;
		wdata = d;
		acceptEdge = cycleCount + 1; // next rising edge accepts
		@(negedge clk);
		cmdValid = 1'b0;
		cmd = cacheCtrlPkg::cmdNone;
		while (!respValid)
			@(negedge clk);
		lastLatency = cycleCount - acceptEdge + 1;
	endtask

	// ------------------------------------------------------------
	// cycle count and timeout
	// ------------------------------------------------------------
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("ERROR: run hung, no finish after %0d cycles", timeoutCycles);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	// response checks
	always @(negedge clk) begin
		if (!reset && respValid) begin
			assert (reqQ.size() > 0)
				else reportFailure("respValid with no outstanding command");
			done = reqQ.pop_front();
			if (done.cmd == cacheCtrlPkg::cmdRead) begin
				expWord = expectedWord(done.addr);
				assert (rdata == expWord)
					else reportMismatch(done.name, expWord, rdata);
			end else if (done.cmd == cacheCtrlPkg::cmdWrite) begin
				shadow[done.addr >> 2] = done.data;
			end
		end
	end

	// memory traffic monitor
	always @(negedge clk) begin
		if (!reset && memRdReq) begin
			assert (memRdAddr[cacheGeomPkg::offsetBits-1:0] == '0)
				else reportFailure("fill address not line aligned");
			rdReqCount++;
			memEvents++;
			rdEventNo = memEvents;
			lastRdAddr = memRdAddr;
		end
		if (!reset && memWrReq) begin
			wrReqCount++;
			memEvents++;
			wrEventNo = memEvents;
			lastWrAddr = memWrAddr;
			lastWrData = memWrData;
			for (int w = 0; w < cacheGeomPkg::wordsPerLine; w++) begin
				wbExpected = expectedWord(memWrAddr + 4 * w);
				assert (memWrData[w*32 +: 32] == wbExpected)
					else reportMismatch("write-back data", wbExpected, memWrData[w*32 +: 32]);
			end
		end
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		clk = 1'b0;
		reset = 1'b1;
		cmdValid = 1'b0;
		cmd = cacheCtrlPkg::cmdNone;
		addr = '0;
		wdata = '0;
		testName = "reset";
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (4) begin
			@(negedge clk);
			assert (!busy && !respValid && !memRdReq && !memWrReq)
				else reportFailure("cache not idle after reset");
		end

		testName = "readMissHit";
		rdBefore = rdReqCount;
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(1, 0, 1), '0);
		assert (rdReqCount == rdBefore + 1)
			else reportFailure("read miss raised no memRdReq");
		assert (lastRdAddr == wordAddress(1, 0, 0))
			else reportMismatch(testName, wordAddress(1, 0, 0), lastRdAddr);
		rdBefore = rdReqCount;
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(1, 0, 2), '0);
		assert (rdReqCount == rdBefore)
			else reportFailure("read hit raised memRdReq");
		assert (lastLatency == hitLatency)
			else reportMismatch("readMissHit latency", hitLatency, lastLatency);

		testName = "writeHitRead";
		rdBefore = rdReqCount;
		wrBefore = wrReqCount;
		runCommand(cacheCtrlPkg::cmdWrite, wordAddress(1, 0, 2), 32'h1234_5678);
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(1, 0, 2), '0);
		assert (rdata == 32'h1234_5678)
			else reportMismatch(testName, 32'h1234_5678, rdata);
		assert (rdReqCount == rdBefore && wrReqCount == wrBefore)
			else reportFailure("write hit caused memory traffic");

		testName = "lruWriteBack"; // all in set 2
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(3, 2, 0), '0);
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(4, 2, 0), '0);
		runCommand(cacheCtrlPkg::cmdWrite, wordAddress(3, 2, 0), 32'hDEAD_0003); // dirty hit
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(4, 2, 1), '0); // touch
		rdBefore = rdReqCount;
		wrBefore = wrReqCount;
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(5, 2, 3), '0);
		assert (wrReqCount == wrBefore + 1)
			else reportFailure("dirty victim was not written back");
		assert (lastWrAddr == wordAddress(3, 2, 0))
			else reportMismatch(testName, wordAddress(3, 2, 0), lastWrAddr);
		assert (lastWrData[31:0] == 32'hDEAD_0003)
			else reportMismatch(testName, 32'hDEAD_0003, lastWrData[31:0]);
		assert (rdReqCount == rdBefore + 1 && wrEventNo < rdEventNo)
			else reportFailure("fill not issued after the write-back");

		testName = "writeMissAllocate";
		rdBefore = rdReqCount;
		runCommand(cacheCtrlPkg::cmdWrite, wordAddress(6, 5, 1), 32'h0BAD_CAFE);
		assert (rdReqCount == rdBefore + 1)
			else reportFailure("write miss did not fill the line");
		assert (lastRdAddr == wordAddress(6, 5, 0))
			else reportMismatch(testName, wordAddress(6, 5, 0), lastRdAddr);
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(6, 5, 3), '0); // pattern word
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(6, 5, 1), '0);
		assert (rdata == 32'h0BAD_CAFE)
			else reportMismatch(testName, 32'h0BAD_CAFE, rdata);

		testName = "invalidate";
		wrBefore = wrReqCount;
		runCommand(cacheCtrlPkg::cmdInvalidate, wordAddress(6, 5, 0), '0);
		assert (wrReqCount == wrBefore + 1)
			else reportFailure("dirty invalidate wrote nothing back");
		assert (lastWrAddr == wordAddress(6, 5, 0))
			else reportMismatch(testName, wordAddress(6, 5, 0), lastWrAddr);
		wrBefore = wrReqCount;
		runCommand(cacheCtrlPkg::cmdInvalidate, wordAddress(4, 2, 0), '0);
		assert (wrReqCount == wrBefore)
			else reportFailure("clean invalidate caused a write-back");
		rdBefore = rdReqCount;
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(6, 5, 1), '0);
		runCommand(cacheCtrlPkg::cmdRead, wordAddress(4, 2, 0), '0);
		assert (rdReqCount == rdBefore + 2)
			else reportFailure("invalidated line still resident");

		testName = "randomMix"; // 4 sets, 6 tags
		for (int i = 0; i < randomCommands; i++) begin
			pick = $unsigned($random(seed)) % 3;
			rndAddr = wordAddress(1 + ($unsigned($random(seed)) % 6),
				$unsigned($random(seed)) % 4, $unsigned($random(seed)) % 4);
			rndData = $random(seed);
			case (pick)
				0: runCommand(cacheCtrlPkg::cmdRead, rndAddr, '0);
				1: runCommand(cacheCtrlPkg::cmdWrite, rndAddr, rndData);
				default: runCommand(cacheCtrlPkg::cmdInvalidate, rndAddr, '0);
			endcase
		end

		if (failCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- src.f
common/cacheGeomPkg.sv
common/cacheCtrlPkg.sv
common/lineAccessIf.sv
common/memReqIf.sv
cache/cacheArrays.sv
cache/cacheController.sv
logic/memRequester.sv
cache/setAssocCache.sv
test/memModel.sv
test/cacheTb.sv
